//--- all.f
design/noc_flit_pkg.sv
design/app_udp_adapter_pkg.sv
design/to_udp_ctrl.sv
design/to_udp_datap.sv
design/noc_out_slice.sv
design/to_udp_top.sv
verif/to_udp_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, decide pass or fail from the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module to_udp_tb \
    -f all.f \
    -o to_udp_sim

./obj_dir/to_udp_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- verif/to_udp_tb.sv
`timescale 1ns/1ns

module to_udp_tb;

    typedef logic [noc_flit_pkg::flit_w-1:0] flit_t;

    // 30 datagrams, about 9 flits of 8 cycles each plus slack
    localparam int timeout_cycles = 30 * (9 * 8 + 20);

    // longest wait for flits still held in the slice
    localparam int drain_cycles = 200;

    logic clk;
    logic rst;
    logic meta_val;
    logic meta_rdy;
    app_udp_adapter_pkg::udp_meta_s meta;
    logic data_val;
    logic data_rdy;
    flit_t data;
    logic noc_val;
    logic noc_rdy;
    flit_t noc_data;

    integer seed = 32'hc819_94eb;
    integer bp_seed;
    bit bp_en;
    int errors = 0;
    int n_checked = 0;
    int cycle_cnt = 0;
    string test_name;
    flit_t exp_q[$];
    string tag_q[$];

    to_udp_top u_dut (
         .clk       (clk)
        ,.rst       (rst)
        ,.meta_val  (meta_val)
        ,.meta_rdy  (meta_rdy)
        ,.meta      (meta)
        ,.data_val  (data_val)
        ,.data_rdy  (data_rdy)
        ,.data      (data)
        ,.noc_val   (noc_val)
        ,.noc_rdy   (noc_rdy)
        ,.noc_data  (noc_data)
    );

    always #4 clk = ~clk;

    task automatic check_val(input string name, input flit_t exp, input flit_t act);
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic int beats_for(input logic [15:0] len);
        int whole;
        whole = int'(len) / app_udp_adapter_pkg::beat_bytes;
        // a partial last beat still takes a flit
        if (int'(len) % app_udp_adapter_pkg::beat_bytes != 0) begin
            whole++;
        end
        return whole;
    endfunction

    // header, metadata flit, then payload as it was sent
    function automatic void expected_flits(input app_udp_adapter_pkg::udp_meta_s m,
                                           input flit_t payload[$]);
        noc_flit_pkg::noc_hdr_flit_s hdr;
        app_udp_adapter_pkg::udp_meta_flit_s mf;
        int n_beats;
        n_beats = beats_for(m.data_len);
        hdr = '0;
        hdr.dst_x = noc_flit_pkg::udp_tile_x;
        hdr.dst_y = noc_flit_pkg::udp_tile_y;
        hdr.msg_len = 8'(n_beats + 1);
        hdr.msg_type = noc_flit_pkg::udp_tx;
        exp_q.push_back(hdr);
        tag_q.push_back("header");
        mf = '0;
        mf.src_ip = m.src_ip;
        mf.dst_ip = m.dst_ip;
        mf.src_port = m.src_port;
        mf.dst_port = m.dst_port;
        mf.data_len = m.data_len;
        exp_q.push_back(mf);
        tag_q.push_back("metadata");
        for (int i = 0; i < n_beats; i++) begin
            exp_q.push_back(payload[i]);
            tag_q.push_back($sformatf("payload %0d", i));
        end
    endfunction

    function automatic app_udp_adapter_pkg::udp_meta_s random_meta(input logic [15:0] len);
        app_udp_adapter_pkg::udp_meta_s m;
        m.src_ip = $random(seed);
        m.dst_ip = $random(seed);
        m.src_port = 16'($random(seed));
        m.dst_port = 16'($random(seed));
        m.data_len = len;
        return m;
    endfunction

    task automatic send_meta(input app_udp_adapter_pkg::udp_meta_s m);
        meta = m;
        meta_val = 1'b1;
        @(posedge clk);
        while (!meta_rdy) @(posedge clk);
        @(negedge clk);
        meta_val = 1'b0;
    endtask

    // random idle cycles between beats
    task automatic send_payload(input flit_t payload[$]);
        for (int i = 0; i < payload.size(); i++) begin
            data_val = 1'b0;
            repeat ({$random(seed)} % 3) @(negedge clk);
            data = payload[i];
            data_val = 1'b1;
            @(posedge clk);
            while (!data_rdy) @(posedge clk);
            @(negedge clk);
        end
        data_val = 1'b0;
    endtask

    task automatic run_datagram(input logic [15:0] len);
        app_udp_adapter_pkg::udp_meta_s m;
        flit_t payload[$];
        m = random_meta(len);
        for (int i = 0; i < beats_for(len); i++) begin
            payload.push_back({$random(seed), $random(seed), $random(seed), $random(seed)});
        end
        expected_flits(m, payload);
        fork
            send_meta(m);
            send_payload(payload);
        join
    endtask

    task automatic drain_and_check(input string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_cycles) begin
            @(negedge clk);
            waited++;
        end
        repeat (4) @(negedge clk);
        check_val({name, " queue empty"}, '0, 128'(exp_q.size()));
    endtask

    always @(posedge clk) begin : compare_noc
        flit_t exp_flit;
        string exp_tag;
        if (!rst && noc_val && noc_rdy) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected flit on the noc while nothing was expected: %h", noc_data);
            end else begin
                exp_flit = exp_q.pop_front();
                exp_tag = tag_q.pop_front();
                n_checked++;
                check_val({test_name, " ", exp_tag}, exp_flit, noc_data);
            end
        end
    end

    // noc_rdy low for 1 to 10 cycles at random
    initial begin : noc_rdy_driver
        int low_len;
        forever begin
            @(negedge clk);
            if (bp_en && ({$random(bp_seed)} % 3 == 0)) begin
                low_len = 1 + int'({$random(bp_seed)} % 10);
                noc_rdy = 1'b0;
                repeat (low_len) @(negedge clk);
                noc_rdy = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("%0d flits checked, %0d errors", n_checked, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        meta_val = 1'b0;
        meta = '0;
        data_val = 1'b0;
        data = '0;
        noc_rdy = 1'b1;
        bp_en = 1'b0;
        bp_seed = seed ^ 32'h0f0f_0f0f;
        test_name = "reset";
        repeat (16) @(negedge clk);
        rst = 1'b0;

        @(posedge clk);
        @(negedge clk);
        check_val("reset noc_val", '0, 128'(noc_val));
        check_val("reset data_rdy", '0, 128'(data_rdy));
        check_val("reset meta_rdy", 128'(1), 128'(meta_rdy));

        // msg_len edges, one and two beats, partial beat, full 128 bytes
        test_name = "header";
        run_datagram(16'd1);
        run_datagram(16'd16);
        run_datagram(16'd17);
        run_datagram(16'd128);
        drain_and_check(test_name);

        test_name = "payload";
        run_datagram(16'd33);
        run_datagram(16'd50);
        run_datagram(16'd80);
        drain_and_check(test_name);

        test_name = "backpressure";
        bp_en = 1'b1;
        for (int i = 0; i < 3; i++) begin
            run_datagram(16'(1 + {$random(seed)} % 96));
        end
        drain_and_check(test_name);
        bp_en = 1'b0;

        test_name = "back_to_back";
        for (int i = 0; i < 20; i++) begin
            run_datagram(16'(1 + {$random(seed)} % 128));
        end
        drain_and_check(test_name);

        $display("%0d flits checked, %0d errors", n_checked, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- design/to_udp_top.sv
`timescale 1ns/1ns

module to_udp_top (
     input  logic                               clk
    ,input  logic                               rst

    ,input  logic                               meta_val
    ,output logic                               meta_rdy
    ,input  app_udp_adapter_pkg::udp_meta_s     meta

    ,input  logic                               data_val
    ,output logic                               data_rdy
    ,input  logic [noc_flit_pkg::flit_w-1:0]    data

    ,output logic                               noc_val
    ,input  logic                               noc_rdy
    ,output logic [noc_flit_pkg::flit_w-1:0]    noc_data
);

    app_udp_adapter_pkg::to_udp_mux_out_e data_mux_sel;
    logic init_state;
    logic cnt_flit;
    logic last_flit;

    // framing stage into the slice
    logic frame_val;
    logic frame_rdy;
    logic [noc_flit_pkg::flit_w-1:0] frame_flit;

    to_udp_ctrl u_ctrl (
         .clk           (clk)
        ,.rst           (rst)
        ,.src_meta_val  (meta_val)
        ,.src_meta_rdy  (meta_rdy)
        ,.src_data_val  (data_val)
        ,.src_data_rdy  (data_rdy)
        ,.noc_val       (frame_val)
        ,.noc_rdy       (frame_rdy)
        ,.data_mux_sel  (data_mux_sel)
        ,.init_state    (init_state)
        ,.cnt_flit      (cnt_flit)
        ,.last_flit     (last_flit)
    );

    to_udp_datap u_datap (
         .clk           (clk)
        ,.rst           (rst)
        ,.meta          (meta)
        ,.data          (data)
        ,.data_mux_sel  (data_mux_sel)
        ,.init_state    (init_state)
        ,.cnt_flit      (cnt_flit)
        ,.last_flit     (last_flit)
        ,.flit          (frame_flit)
    );

    noc_out_slice u_slice (
         .clk           (clk)
        ,.rst           (rst)
        ,.in_val        (frame_val)
        ,.in_flit       (frame_flit)
        ,.in_rdy        (frame_rdy)
        ,.out_val       (noc_val)
        ,.out_rdy       (noc_rdy)
        ,.out_flit      (noc_data)
    );

endmodule

//--- design/noc_out_slice.sv
`timescale 1ns/1ns

module noc_out_slice (
     input  logic                               clk
    ,input  logic                               rst

    ,input  logic                               in_val
    ,input  logic [noc_flit_pkg::flit_w-1:0]    in_flit
    ,output logic                               in_rdy

    ,output logic                               out_val
    ,input  logic                               out_rdy
    ,output logic [noc_flit_pkg::flit_w-1:0]    out_flit
);

    logic skid_val;
    logic [noc_flit_pkg::flit_w-1:0] skid_flit;
    logic in_fire;
    logic out_free;

    // ready comes straight from the skid flop
    assign in_rdy = ~skid_val;
    assign in_fire = in_val & in_rdy;
    // output entry can take a new flit this cycle
    assign out_free = out_rdy | ~out_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_val <= 1'b0;
            skid_val <= 1'b0;
        end else if (out_free) begin
            if (skid_val) begin
                out_val <= 1'b1;
                skid_val <= 1'b0;
            end else begin
                out_val <= in_fire;
            end
        end else if (in_fire) begin
            skid_val <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_flit <= skid_val ? skid_flit : in_flit;
        end
        if (!out_free && in_fire) begin
            skid_flit <= in_flit;
        end
    end

    out_stable_a: assert property (@(posedge clk) disable iff (rst)
        (out_val && !out_rdy) |=> (out_val && $stable(out_flit)));

endmodule

//--- design/to_udp_datap.sv
`timescale 1ns/1ns

module to_udp_datap (
     input  logic                                   clk
    ,input  logic                                   rst

    ,input  app_udp_adapter_pkg::udp_meta_s         meta
    ,input  logic [noc_flit_pkg::flit_w-1:0]        data

    ,input  app_udp_adapter_pkg::to_udp_mux_out_e   data_mux_sel
    ,input  logic                                   init_state
    ,input  logic                                   cnt_flit

    ,output logic                                   last_flit
    ,output logic [noc_flit_pkg::flit_w-1:0]        flit
);

    app_udp_adapter_pkg::udp_meta_s meta_reg;
    app_udp_adapter_pkg::udp_meta_flit_s meta_flit;
    noc_flit_pkg::noc_hdr_flit_s hdr_flit;

    logic [16:0] len_round;
    logic [16:0] beat_cnt;
    logic [16:0] msg_len_full;
    logic [7:0] msg_len;
    logic [7:0] flit_cnt;

    // metadata tracks the input until the FSM leaves ready
    always_ff @(posedge clk) begin
        if (init_state) begin
            meta_reg <= meta;
        end
    end

    // counts the metadata flit and every payload flit
    always_ff @(posedge clk) begin
        if (rst || init_state) begin
            flit_cnt <= 8'd0;
        end else if (cnt_flit) begin
            flit_cnt <= flit_cnt + 8'd1;
        end
    end

    // one metadata flit plus payload beats, rounded up
    assign len_round = {1'b0, meta_reg.data_len}
                     + 17'(app_udp_adapter_pkg::beat_bytes - 1);
    assign beat_cnt = len_round / 17'(app_udp_adapter_pkg::beat_bytes);
    assign msg_len_full = beat_cnt + 17'd1;
    assign msg_len = msg_len_full[7:0];

    assign last_flit = (flit_cnt == (msg_len - 8'd1));

    always_comb begin
        hdr_flit = '0;
        hdr_flit.dst_x = noc_flit_pkg::udp_tile_x;
        hdr_flit.dst_y = noc_flit_pkg::udp_tile_y;
        hdr_flit.msg_len = msg_len;
        hdr_flit.msg_type = noc_flit_pkg::udp_tx;
    end

    always_comb begin
        meta_flit = '0;
        meta_flit.src_ip = meta_reg.src_ip;
        meta_flit.dst_ip = meta_reg.dst_ip;
        meta_flit.src_port = meta_reg.src_port;
        meta_flit.dst_port = meta_reg.dst_port;
        meta_flit.data_len = meta_reg.data_len;
    end

    always_comb begin
        case (data_mux_sel)
            app_udp_adapter_pkg::meta_out: flit = meta_flit;
            app_udp_adapter_pkg::data_out: flit = data;
            default: flit = hdr_flit;
        endcase
    end

    // zero length datagrams are not framed
    nonzero_len_a: assert property (@(posedge clk) disable iff (rst)
        !init_state |-> (meta_reg.data_len != 16'd0));

endmodule

//--- design/to_udp_ctrl.sv
`timescale 1ns/1ns

module to_udp_ctrl (
     input  logic                                   clk
    ,input  logic                                   rst

    ,input  logic                                   src_meta_val
    ,output logic                                   src_meta_rdy

    ,input  logic                                   src_data_val
    ,output logic                                   src_data_rdy

    ,output logic                                   noc_val
    ,input  logic                                   noc_rdy

    ,output app_udp_adapter_pkg::to_udp_mux_out_e   data_mux_sel
    ,output logic                                   init_state
    ,output logic                                   cnt_flit

    ,input  logic                                   last_flit
);

    typedef enum logic [1:0] {
        ready = 2'd0,
        hdr_flit_out = 2'd1,
        meta_flit_out = 2'd2,
        data_passthru = 2'd3
    } state_e;

    state_e state_reg;
    state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= ready;
        end else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        src_meta_rdy = 1'b0;
        src_data_rdy = 1'b0;
        noc_val = 1'b0;
        cnt_flit = 1'b0;
        init_state = 1'b0;
        data_mux_sel = app_udp_adapter_pkg::hdr_out;
        state_next = state_reg;

        case (state_reg)
            ready: begin
                init_state = 1'b1;
                src_meta_rdy = 1'b1;
                if (src_meta_val) begin
                    state_next = hdr_flit_out;
                end
            end
            hdr_flit_out: begin
                noc_val = 1'b1;
                if (noc_rdy) begin
                    state_next = meta_flit_out;
                end
            end
            meta_flit_out: begin
                noc_val = 1'b1;
                data_mux_sel = app_udp_adapter_pkg::meta_out;
                if (noc_rdy) begin
                    cnt_flit = 1'b1;
                    state_next = data_passthru;
                end
            end
            data_passthru: begin
                // payload goes straight through to the slice
                data_mux_sel = app_udp_adapter_pkg::data_out;
                noc_val = src_data_val;
                src_data_rdy = noc_rdy;
                if (src_data_val && noc_rdy) begin
                    cnt_flit = 1'b1;
                    if (last_flit) begin
                        state_next = ready;
                    end
                end
            end
            default: begin
                state_next = ready;
            end
        endcase
    end

    state_known_a: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state_reg));

    data_rdy_only_passthru_a: assert property (@(posedge clk) disable iff (rst)
        src_data_rdy |-> (state_reg == data_passthru));

endmodule

//--- design/app_udp_adapter_pkg.sv
package app_udp_adapter_pkg;

    // payload bytes carried by one flit
    localparam int beat_bytes = 16;

    // one beat per datagram from the application
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        // payload length in bytes
        logic [15:0] data_len;
    } udp_meta_s;

    // second flit of the message, zero filled at the bottom
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] data_len;
        logic [15:0] pad;
    } udp_meta_flit_s;

    // outgoing flit select
    typedef enum logic [1:0] {
        hdr_out = 2'd0,
        meta_out = 2'd1,
        data_out = 2'd2
    } to_udp_mux_out_e;

endpackage

//--- design/noc_flit_pkg.sv
package noc_flit_pkg;

    // mesh flit width in bits
    localparam int flit_w = 128;

    // coordinates of the tile that hosts the UDP engine
    localparam logic [7:0] udp_tile_x = 8'd2;
    localparam logic [7:0] udp_tile_y = 8'd1;

    localparam int hdr_used_w = 32;
    localparam int hdr_pad_w = flit_w - hdr_used_w;

    typedef enum logic [7:0] {
        msg_none = 8'h00,
        udp_rx = 8'h10,
        udp_tx = 8'h11
    } noc_msg_type_e;

    // first flit of every message
    typedef struct packed {
        logic [7:0] dst_x;
        logic [7:0] dst_y;
        // flits that follow the header
        logic [7:0] msg_len;
        noc_msg_type_e msg_type;
        logic [hdr_pad_w-1:0] pad;
    } noc_hdr_flit_s;

endpackage
